// File: design/exec_pkg.sv
package exec_pkg;

    localparam int xlen     = 32;
    localparam int br_bits  = 4;
    localparam int tag_bits = 5;

    typedef logic [xlen-1:0]     data_t;
    typedef logic [br_bits-1:0]  b_mask_t;
    typedef logic [tag_bits-1:0] tag_t;

    typedef enum logic [1:0] {
        opa_rs1,
        opa_npc,
        opa_pc,
        opa_zero
    } opa_sel_t;

    typedef enum logic [2:0] {
        opb_rs2,
        opb_i_imm,
        opb_s_imm,
        opb_b_imm,
        opb_u_imm,
        opb_j_imm
    } opb_sel_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_slt,
        alu_sltu,
        alu_or,
        alu_xor,
        alu_srl,
        alu_sll,
        alu_sra
    } alu_func_t;

    typedef enum logic [2:0] {
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } br_func_t;

    typedef enum logic {
        fu_alu,
        fu_branch
    } fu_sel_t;

    typedef enum logic [1:0] {
        br_none,
        br_clear,
        br_squash
    } br_task_t;

    typedef struct packed {
        logic      valid;
        fu_sel_t   fu;
        tag_t      tag;
        data_t     pc;
        data_t     npc;
        data_t     inst;
        opa_sel_t  opa_select;
        opb_sel_t  opb_select;
        alu_func_t alu_func;
        br_func_t  br_func;
        logic      pred_taken;
        data_t     pred_target;
        b_mask_t   b_mask;
        b_mask_t   b_id;
        data_t     rs1_value;
        data_t     rs2_value;
    } issue_packet;

    typedef struct packed {
        tag_t    tag;
        b_mask_t b_mask;
        data_t   result;
        logic    is_branch;
        logic    pred_correct;
    } fu_packet;

    // The b_id is one-hot, so it can be matched directly against a b_mask.
    typedef struct packed {
        br_task_t br_task;
        b_mask_t  b_id;
    } br_resolve;

    function automatic data_t imm_i(input data_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic data_t imm_s(input data_t inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic data_t imm_b(input data_t inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(input data_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(input data_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                  clock,
    input  logic                  reset,
    input  exec_pkg::issue_packet is_pack,
    input  logic                  stall,
    input  logic                  rd_in,
    input  exec_pkg::br_resolve   resolve,
    output exec_pkg::fu_packet    fu_pack,
    output logic                  data_ready
);

    exec_pkg::data_t    opa;
    exec_pkg::data_t    opb;
    exec_pkg::data_t    result;
    logic [4:0]         shamt;
    exec_pkg::b_mask_t  in_mask;
    exec_pkg::b_mask_t  held_mask;
    exec_pkg::fu_packet fu_q;
    logic               ready_q;
    logic               do_clear;
    logic               squash_in;
    logic               squash_held;

    assign do_clear    = resolve.br_task == exec_pkg::br_clear;
    assign squash_in   = resolve.br_task == exec_pkg::br_squash &&
                         (is_pack.b_mask & resolve.b_id) != '0;
    assign squash_held = resolve.br_task == exec_pkg::br_squash &&
                         (fu_q.b_mask & resolve.b_id) != '0;

    assign in_mask   = do_clear ? is_pack.b_mask & ~resolve.b_id : is_pack.b_mask;
    assign held_mask = do_clear ? fu_q.b_mask & ~resolve.b_id : fu_q.b_mask;

    always_comb begin
        case (is_pack.opa_select)
            exec_pkg::opa_rs1:  opa = is_pack.rs1_value;
            exec_pkg::opa_npc:  opa = is_pack.npc;
            exec_pkg::opa_pc:   opa = is_pack.pc;
            default:            opa = '0;
        endcase
    end

    always_comb begin
        case (is_pack.opb_select)
            exec_pkg::opb_rs2:   opb = is_pack.rs2_value;
            exec_pkg::opb_i_imm: opb = exec_pkg::imm_i(is_pack.inst);
            exec_pkg::opb_s_imm: opb = exec_pkg::imm_s(is_pack.inst);
            exec_pkg::opb_b_imm: opb = exec_pkg::imm_b(is_pack.inst);
            exec_pkg::opb_u_imm: opb = exec_pkg::imm_u(is_pack.inst);
            exec_pkg::opb_j_imm: opb = exec_pkg::imm_j(is_pack.inst);
            default:             opb = '0;
        endcase
    end

    assign shamt = opb[4:0];

    always_comb begin
        case (is_pack.alu_func)
            exec_pkg::alu_add:  result = opa + opb;
            exec_pkg::alu_sub:  result = opa - opb;
            exec_pkg::alu_and:  result = opa & opb;
            exec_pkg::alu_slt:  result = {31'b0, $signed(opa) < $signed(opb)};
            exec_pkg::alu_sltu: result = {31'b0, opa < opb};
            exec_pkg::alu_or:   result = opa | opb;
            exec_pkg::alu_xor:  result = opa ^ opb;
            exec_pkg::alu_srl:  result = opa >> shamt;
            exec_pkg::alu_sll:  result = opa << shamt;
            exec_pkg::alu_sra:  result = $signed(opa) >>> shamt;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b0;
        end else if (stall) begin
            ready_q <= ready_q && !squash_held;
        end else begin
            ready_q <= rd_in && !squash_in;
        end
    end

    always_ff @(posedge clock) begin
        if (stall ? squash_held : (rd_in && squash_in)) begin
            fu_q <= '0;
        end else if (stall) begin
            fu_q.b_mask <= held_mask;
        end else if (rd_in) begin
            fu_q <= '{tag: is_pack.tag, b_mask: in_mask, result: result,
                      is_branch: 1'b0, pred_correct: 1'b0};
        end
    end

    // A resolution in the current cycle also applies to the packet on its way to the bus,
    // so a squashed op never completes and a cleared one leaves with its bit removed.
    always_comb begin
        fu_pack        = fu_q;
        fu_pack.b_mask = held_mask;
    end

    assign data_ready = ready_q && !squash_held;

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  exec_pkg::issue_packet is_pack,
    input  logic                  stall,
    input  logic                  rd_in,
    output exec_pkg::fu_packet    fu_pack,
    output logic                  data_ready,
    output exec_pkg::br_resolve   resolve
);

    exec_pkg::data_t rs1;
    exec_pkg::data_t rs2;
    exec_pkg::data_t target;
    logic            taken;
    logic            correct;

    assign rs1 = is_pack.rs1_value;
    assign rs2 = is_pack.rs2_value;

    always_comb begin
        taken = 1'b0;
        case (is_pack.br_func)
            exec_pkg::br_beq:  taken = rs1 == rs2;
            exec_pkg::br_bne:  taken = rs1 != rs2;
            exec_pkg::br_blt:  taken = $signed(rs1) < $signed(rs2);
            exec_pkg::br_bge:  taken = $signed(rs1) >= $signed(rs2);
            exec_pkg::br_bltu: taken = rs1 < rs2;
            exec_pkg::br_bgeu: taken = rs1 >= rs2;
            exec_pkg::br_jal:  taken = 1'b1;
            exec_pkg::br_jalr: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        case (is_pack.br_func)
            exec_pkg::br_jal: begin
                target = is_pack.pc + exec_pkg::imm_j(is_pack.inst);
            end
            exec_pkg::br_jalr: begin
                target = (rs1 + exec_pkg::imm_i(is_pack.inst)) & ~exec_pkg::data_t'(1);
            end
            default: begin
                target = is_pack.pc + exec_pkg::imm_b(is_pack.inst);
            end
        endcase
    end

    // A not-taken prediction is right whatever target was predicted.
    assign correct = (taken == is_pack.pred_taken) &&
                     (!taken || target == is_pack.pred_target);

    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready      <= 1'b0;
            resolve.br_task <= exec_pkg::br_none;
            resolve.b_id    <= '0;
        end else if (stall) begin
            // The broadcast went out when the branch was loaded.
            resolve.br_task <= exec_pkg::br_none;
            resolve.b_id    <= '0;
        end else if (rd_in) begin
            data_ready      <= 1'b1;
            resolve.br_task <= correct ? exec_pkg::br_clear : exec_pkg::br_squash;
            resolve.b_id    <= is_pack.b_id;
        end else begin
            data_ready      <= 1'b0;
            resolve.br_task <= exec_pkg::br_none;
            resolve.b_id    <= '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall && rd_in) begin
            fu_pack <= '{tag: is_pack.tag, b_mask: is_pack.b_mask, result: is_pack.npc,
                         is_branch: 1'b1, pred_correct: correct};
        end
    end

endmodule

// File: design/complete_arbiter.sv
`timescale 1ns/1ps

module complete_arbiter (
    input  logic               clock,
    input  logic               reset,
    input  exec_pkg::fu_packet alu_pack,
    input  exec_pkg::fu_packet branch_pack,
    input  logic               alu_done,
    input  logic               branch_done,
    output exec_pkg::fu_packet cdb,
    output logic               cdb_valid,
    output logic               alu_stall,
    output logic               branch_stall
);

    logic last_alu;
    logic grant_alu;
    logic grant_branch;

    // On a conflict the unit that was not granted last time goes first.
    assign grant_alu    = alu_done && (!branch_done || !last_alu);
    assign grant_branch = branch_done && !grant_alu;

    assign cdb       = grant_alu ? alu_pack : branch_pack;
    assign cdb_valid = grant_alu || grant_branch;

    // A unit stalls only when it has a result and loses.
    assign alu_stall    = alu_done && !grant_alu;
    assign branch_stall = branch_done && !grant_branch;

    always_ff @(posedge clock) begin
        if (reset) begin
            last_alu <= 1'b0;
        end else if (grant_alu) begin
            last_alu <= 1'b1;
        end else if (grant_branch) begin
            last_alu <= 1'b0;
        end
    end

endmodule

// File: design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  exec_pkg::issue_packet issue,
    output logic                  alu_ready,
    output logic                  branch_ready,
    output exec_pkg::fu_packet    cdb,
    output logic                  cdb_valid,
    output exec_pkg::br_resolve   resolve
);

    exec_pkg::fu_packet alu_pack;
    exec_pkg::fu_packet branch_pack;
    logic               alu_done;
    logic               branch_done;
    logic               alu_stall;
    logic               branch_stall;
    logic               alu_rd;
    logic               branch_rd;

    // Each op goes to exactly one unit, chosen by its fu field.
    assign alu_rd    = issue.valid && issue.fu == exec_pkg::fu_alu;
    assign branch_rd = issue.valid && issue.fu == exec_pkg::fu_branch;

    alu i_alu (
        .clock      (clock),
        .reset      (reset),
        .is_pack    (issue),
        .stall      (alu_stall),
        .rd_in      (alu_rd),
        .resolve    (resolve),
        .fu_pack    (alu_pack),
        .data_ready (alu_done)
    );

    branch_unit i_branch_unit (
        .clock      (clock),
        .reset      (reset),
        .is_pack    (issue),
        .stall      (branch_stall),
        .rd_in      (branch_rd),
        .fu_pack    (branch_pack),
        .data_ready (branch_done),
        .resolve    (resolve)
    );

    complete_arbiter i_complete_arbiter (
        .clock        (clock),
        .reset        (reset),
        .alu_pack     (alu_pack),
        .branch_pack  (branch_pack),
        .alu_done     (alu_done),
        .branch_done  (branch_done),
        .cdb          (cdb),
        .cdb_valid    (cdb_valid),
        .alu_stall    (alu_stall),
        .branch_stall (branch_stall)
    );

    assign alu_ready    = !alu_stall;
    assign branch_ready = !branch_stall;

endmodule

// File: verification/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Result of an ALU op from its operand selects, its function and its operands.
function automatic exec_pkg::data_t model_alu(input exec_pkg::issue_packet p);
    exec_pkg::data_t a;
    exec_pkg::data_t b;
    logic [4:0]      sh;
    case (p.opa_select)
        exec_pkg::opa_rs1: a = p.rs1_value;
        exec_pkg::opa_npc: a = p.npc;
        exec_pkg::opa_pc:  a = p.pc;
        default:           a = '0;
    endcase
    case (p.opb_select)
        exec_pkg::opb_rs2:   b = p.rs2_value;
        exec_pkg::opb_i_imm: b = exec_pkg::imm_i(p.inst);
        exec_pkg::opb_s_imm: b = exec_pkg::imm_s(p.inst);
        exec_pkg::opb_b_imm: b = exec_pkg::imm_b(p.inst);
        exec_pkg::opb_u_imm: b = exec_pkg::imm_u(p.inst);
        default:             b = exec_pkg::imm_j(p.inst);
    endcase
    sh = b[4:0];
    case (p.alu_func)
        exec_pkg::alu_add:  return a + b;
        exec_pkg::alu_sub:  return a - b;
        exec_pkg::alu_and:  return a & b;
        // Flipping both sign bits turns a signed compare into an unsigned one.
        exec_pkg::alu_slt:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        exec_pkg::alu_sltu: return {31'b0, a < b};
        exec_pkg::alu_or:   return a | b;
        exec_pkg::alu_xor:  return a ^ b;
        exec_pkg::alu_srl:  return a >> sh;
        exec_pkg::alu_sll:  return a << sh;
        default:            return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
    endcase
endfunction

function automatic logic model_taken(input exec_pkg::issue_packet p);
    logic signed_lt;
    signed_lt = (p.rs1_value ^ 32'h8000_0000) < (p.rs2_value ^ 32'h8000_0000);
    case (p.br_func)
        exec_pkg::br_beq:  return p.rs1_value == p.rs2_value;
        exec_pkg::br_bne:  return p.rs1_value != p.rs2_value;
        exec_pkg::br_blt:  return signed_lt;
        exec_pkg::br_bge:  return !signed_lt;
        exec_pkg::br_bltu: return p.rs1_value < p.rs2_value;
        exec_pkg::br_bgeu: return p.rs1_value >= p.rs2_value;
        default:           return 1'b1;
    endcase
endfunction

function automatic exec_pkg::data_t model_target(input exec_pkg::issue_packet p);
    exec_pkg::data_t sum;
    sum = p.rs1_value + exec_pkg::imm_i(p.inst);
    case (p.br_func)
        exec_pkg::br_jal:  return p.pc + exec_pkg::imm_j(p.inst);
        exec_pkg::br_jalr: return {sum[31:1], 1'b0};
        default:           return p.pc + exec_pkg::imm_b(p.inst);
    endcase
endfunction

// A taken branch needs the right target as well as the right direction.
function automatic logic model_correct(input exec_pkg::issue_packet p);
    return model_taken(p) == p.pred_taken &&
           (!model_taken(p) || model_target(p) == p.pred_target);
endfunction

function automatic logic hits_branch(input exec_pkg::b_mask_t mask,
                                     input exec_pkg::b_mask_t id);
    return (mask & id) != '0;
endfunction

function automatic exec_pkg::b_mask_t cleared_mask(input exec_pkg::b_mask_t mask,
                                                   input exec_pkg::b_mask_t id);
    return mask & ~id;
endfunction

`endif

// File: verification/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage;

    logic                  clock;
    logic                  reset;
    exec_pkg::issue_packet issue;
    logic                  alu_ready;
    logic                  branch_ready;
    exec_pkg::fu_packet    cdb;
    logic                  cdb_valid;
    exec_pkg::br_resolve   resolve;

    // Scoreboard of expected results, indexed by tag.
    logic               pend [32];
    exec_pkg::fu_packet expect_pack [32];
    int                 issued_at [32];
    logic [31:0]        rng;
    logic               br_open;
    exec_pkg::b_mask_t  br_id;
    exec_pkg::br_task_t br_task_exp;
    int                 br_issued_at;
    exec_pkg::tag_t     next_tag;
    int                 outstanding;
    int                 errors;
    int                 test_errors;
    int                 tests_failed;
    int                 squashed;
    int                 cyc = 0;

    `include "exec_model.svh"

    exec_stage i_dut (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .alu_ready    (alu_ready),
        .branch_ready (branch_ready),
        .cdb          (cdb),
        .cdb_valid    (cdb_valid),
        .resolve      (resolve)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic build_op(input logic to_branch, input int pred_mode,
                            output exec_pkg::issue_packet p);
        logic [31:0] r;
        r = next_rand();
        p = '0;
        p.valid     = 1'b1;
        p.tag       = next_tag;
        p.pc        = next_rand() & ~32'h3;
        p.npc       = p.pc + 32'd4;
        p.inst      = next_rand();
        p.rs1_value = next_rand();
        // Equal or small second operands now and then, for equality and shift cases.
        p.rs2_value = r[0] ? p.rs1_value : (r[1] ? {27'b0, r[6:2]} : next_rand());
        p.opa_select = exec_pkg::opa_sel_t'(r[8:7]);
        p.opb_select = exec_pkg::opb_sel_t'(r[11:9] % 3'd6);
        p.alu_func   = exec_pkg::alu_func_t'(r[15:12] % 4'd10);
        p.br_func    = exec_pkg::br_func_t'(r[18:16]);
        if (to_branch) begin
            p.fu          = exec_pkg::fu_branch;
            p.b_id        = exec_pkg::b_mask_t'(1 << r[20:19]);
            p.pred_taken  = pred_mode == 2 ? r[21] : model_taken(p) ^ (pred_mode == 1);
            p.pred_target = pred_mode == 2 && r[22] ? next_rand() : model_target(p);
            expect_pack[next_tag] = '{tag: next_tag, b_mask: '0, result: p.npc,
                                      is_branch: 1'b1, pred_correct: model_correct(p)};
            br_task_exp  = model_correct(p) ? exec_pkg::br_clear : exec_pkg::br_squash;
            br_id        = p.b_id;
            br_open      = 1'b1;
            br_issued_at = cyc;
        end else begin
            p.fu     = exec_pkg::fu_alu;
            p.b_mask = br_open ? br_id : '0;
            expect_pack[next_tag] = '{tag: next_tag, b_mask: p.b_mask, result: model_alu(p),
                                      is_branch: 1'b0, pred_correct: 1'b0};
        end
        pend[next_tag]      = 1'b1;
        issued_at[next_tag] = cyc;
        outstanding++;
        next_tag++;
    endtask

    // Called at the falling edge, where every DUT output is settled for the cycle.
    task automatic watch();
        int i;
        int lat;
        if (resolve.br_task != exec_pkg::br_none) begin
            if (!br_open) begin
                report_failure("resolve pulsed with no branch outstanding");
            end else begin
                if (cyc - br_issued_at != 2) begin
                    report_failure($sformatf("resolve pulsed %0d cycles after issue",
                                             cyc - br_issued_at));
                end
                if (resolve.br_task != br_task_exp) begin
                    report_mismatch("resolve.br_task", 32'(resolve.br_task), 32'(br_task_exp));
                end
                if (resolve.b_id != br_id) begin
                    report_mismatch("resolve.b_id", 32'(resolve.b_id), 32'(br_id));
                end
                for (i = 0; i < 32; i++) begin
                    if (pend[i[4:0]] && !expect_pack[i[4:0]].is_branch &&
                        hits_branch(expect_pack[i[4:0]].b_mask, br_id)) begin
                        if (br_task_exp == exec_pkg::br_squash) begin
                            pend[i[4:0]] = 1'b0;
                            outstanding--;
                            squashed++;
                        end else begin
                            expect_pack[i[4:0]].b_mask =
                                cleared_mask(expect_pack[i[4:0]].b_mask, br_id);
                        end
                    end
                end
                br_open = 1'b0;
            end
        end
        if (cdb_valid) begin
            if (!pend[cdb.tag]) begin
                report_failure($sformatf("tag %0d completed with no op outstanding", cdb.tag));
            end else begin
                // One cycle after the op is loaded, or one more if it lost arbitration.
                lat = cyc - issued_at[cdb.tag];
                if (lat < 2 || lat > 3) begin
                    report_failure($sformatf("tag %0d completed %0d cycles after issue",
                                             cdb.tag, lat));
                end
                if (cdb.result != expect_pack[cdb.tag].result) begin
                    report_mismatch("cdb.result", cdb.result, expect_pack[cdb.tag].result);
                end
                if (cdb.b_mask != expect_pack[cdb.tag].b_mask) begin
                    report_mismatch("cdb.b_mask", 32'(cdb.b_mask),
                                    32'(expect_pack[cdb.tag].b_mask));
                end
                if (cdb.is_branch != expect_pack[cdb.tag].is_branch) begin
                    report_mismatch("cdb.is_branch", 32'(cdb.is_branch),
                                    32'(expect_pack[cdb.tag].is_branch));
                end
                if (cdb.pred_correct != expect_pack[cdb.tag].pred_correct) begin
                    report_mismatch("cdb.pred_correct", 32'(cdb.pred_correct),
                                    32'(expect_pack[cdb.tag].pred_correct));
                end
                pend[cdb.tag] = 1'b0;
                outstanding--;
            end
        end
        if (!alu_ready && !(cdb_valid && cdb.is_branch)) begin
            report_mismatch("alu_ready", 32'(alu_ready), 32'd1);
        end
        if (!branch_ready && !(cdb_valid && !cdb.is_branch)) begin
            report_mismatch("branch_ready", 32'(branch_ready), 32'd1);
        end
    endtask

    task automatic run_test(input string name, input int n_ops, input int branch_pct,
                            input int pred_mode);
        exec_pkg::issue_packet p;
        logic [31:0]           r;
        int                    issued;
        int                    cycles;
        test_errors = 0;
        squashed    = 0;
        issued      = 0;
        cycles      = 0;
        while (issued < n_ops && cycles < 50 * n_ops) begin
            @(negedge clock);
            watch();
            p = '0;
            r = next_rand();
            if (!pend[next_tag] && r % 100 < branch_pct && !br_open && branch_ready) begin
                build_op(1'b1, pred_mode, p);
                issued++;
            end else if (!pend[next_tag] && r[31] && alu_ready) begin
                build_op(1'b0, pred_mode, p);
                issued++;
            end
            @(posedge clock);
            issue <= p;
            cycles++;
        end
        if (issued < n_ops) begin
            report_failure($sformatf("test %s issued only %0d ops in time", name, issued));
        end
        cycles = 0;
        while ((outstanding > 0 || br_open) && cycles < 20) begin
            @(negedge clock);
            watch();
            @(posedge clock);
            issue <= '0;
            cycles++;
        end
        if (outstanding > 0 || br_open) begin
            report_failure($sformatf("test %s timed out with %0d results missing",
                                     name, outstanding));
        end
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("test %-14s issued %0d, squashed %0d, errors %0d",
                 name, issued, squashed, test_errors);
    endtask

    initial begin
        int i;
        clock = 1'b0;
        reset <= 1'b1;
        issue <= '0;
        rng = 32'd6;
        br_open = 1'b0;
        br_id = '0;
        br_task_exp = exec_pkg::br_none;
        br_issued_at = 0;
        next_tag = '0;
        outstanding = 0;
        errors = 0;
        tests_failed = 0;
        test_errors = 0;
        for (i = 0; i < 32; i++) begin
            pend[i[4:0]] = 1'b0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (cdb_valid !== 1'b0) begin
            report_mismatch("cdb_valid", 32'(cdb_valid), 32'd0);
        end
        if (resolve.br_task !== exec_pkg::br_none) begin
            report_mismatch("resolve.br_task", 32'(resolve.br_task), 32'(exec_pkg::br_none));
        end
        if (alu_ready !== 1'b1) begin
            report_mismatch("alu_ready", 32'(alu_ready), 32'd1);
        end
        if (branch_ready !== 1'b1) begin
            report_mismatch("branch_ready", 32'(branch_ready), 32'd1);
        end
        if (test_errors > 0) begin
            tests_failed++;
        end
        $display("test %-14s errors %0d", "reset", test_errors);
        run_test("alu_only", 300, 0, 0);
        run_test("branch_clear", 300, 30, 0);
        run_test("branch_squash", 300, 30, 1);
        run_test("mixed", 600, 20, 2);
        $display("tests 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
design/exec_pkg.sv
design/alu.sv
design/branch_unit.sv
design/complete_arbiter.sv
design/exec_stage.sv
verification/tb_exec_stage.sv

// File: Makefile
SOURCES := $(wildcard design/*.sv verification/*.sv verification/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_exec_stage
	@out=$$(obj_dir/Vtb_exec_stage); echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

obj_dir/Vtb_exec_stage: verilog.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module tb_exec_stage -f verilog.f \
		-o Vtb_exec_stage

clean:
	rm -rf obj_dir
